//--- vlog.f
adpcm_pkg.sv
adpcm_regs.sv
adpcm_seq.sv
adpcm_decoder.sv
adpcm_player.sv
tb_clkgen.sv
adpcm_tb.sv

//--- Makefile
# Verilator build and run of the ADPCM player testbench

VERILATOR ?= verilator
TOP       ?= adpcm_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- adpcm_tb.sv
// ADPCM player testbench
// ROM model, reference ADPCM model and directed tests
// for playback, end page, stop, saturation and bus qualification
`timescale 1ns/1ps

module adpcm_tb import adpcm_pkg::*; ();

localparam int pb_w         = 3;          // log2 bytes per page
localparam int rdiv         = 3;          // cen_oki pulses per sample
localparam int nib_per_page = 2 << pb_w;  // 16 samples per page
localparam int play_limit   = 400;        // one page is about 100 clocks
localparam int max_cycles   = 20000;      // whole run is well under 2000 clocks

logic               clk;
logic               ad_rst   = 1'b0;
logic               cpu_cen  = 1'b0;
logic               cen_oki  = 1'b0;
logic [7:0]         cpu_dout = 8'h00;
adpcm_op_e          cpu_ab   = op_start;
logic               cs       = 1'b0;
logic [7:0]         rom_data = 8'h00;
logic [15:0]        rom_addr;
logic               rom_cs;
logic signed [11:0] snd;
logic               sample;

logic [7:0] rom [65536]; // sample ROM image
int         model_acc;   // reference accumulator
int         model_idx;   // reference step index
int         end_lag;     // clocks from the last sample to rom_cs low
int         n_errors = 0;
int         n_checks = 0;
int         cycles   = 0;

tb_clkgen #(.period(40)) u_clk (.clk(clk));

adpcm_player #(.page_bytes_w(pb_w), .rate_div(rdiv)) UUT (
    .clk      ( clk      ),
    .ad_rst   ( ad_rst   ),
    .cpu_cen  ( cpu_cen  ),
    .cen_oki  ( cen_oki  ),
    .cpu_dout ( cpu_dout ),
    .cpu_ab   ( cpu_ab   ),
    .cs       ( cs       ),
    .rom_data ( rom_data ),
    .rom_addr ( rom_addr ),
    .rom_cs   ( rom_cs   ),
    .snd      ( snd      ),
    .sample   ( sample   )
);

// cen_oki on every second clock
always @(posedge clk) begin
    if (!ad_rst)
        cen_oki <= 1'b0;
    else
        cen_oki <= ~cen_oki;
end

// ROM answers one clock after the address
always @(posedge clk) rom_data <= rom[rom_addr];

// hang guard
always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
        $display("timeout: test did not finish within %0d clock cycles", max_cycles);
        $display("sim failed");
        $finish;
    end
end

task automatic check_snd(input logic signed [11:0] got, input logic signed [11:0] exp,
                         input string what);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("FAIL at %0t: %s, snd %0d expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("FAIL at %0t: %s, got %b expected %b", $time, what, got, exp);
    end
endtask

task automatic check_addr(input logic [15:0] got, input logic [15:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("FAIL at %0t: %s, rom_addr %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_count(input int got, input int exp, input string what);
    n_checks++;
    if (got != exp) begin
        n_errors++;
        $display("FAIL at %0t: %s, count %0d expected %0d", $time, what, got, exp);
    end
endtask

task automatic note_error(input string what);
    n_errors++;
    $display("ERROR at %0t: %s", $time, what);
endtask

// one bus cycle, sampled on the following edge
task automatic write_raw(input logic cs_v, input logic cen_v, input adpcm_op_e op,
                         input logic [7:0] data);
    @(posedge clk);
    cs       <= cs_v;
    cpu_cen  <= cen_v;
    cpu_ab   <= op;
    cpu_dout <= data;
    @(posedge clk);
    cs       <= 1'b0;
    cpu_cen  <= 1'b1; // back to every clock
endtask

task automatic cpu_write(input adpcm_op_e op, input logic [7:0] data);
    write_raw(1'b1, 1'b1, op, data);
endtask

// OKI rule, worked in plain integers
task automatic model_step(input logic [3:0] nib);
    int step;
    int diff;
    int acc;
    int idx;
    step = int'(adpcm_steps[model_idx]);
    diff = step / 8;
    if (nib[0])
        diff += step / 4;
    if (nib[1])
        diff += step / 2;
    if (nib[2])
        diff += step;
    acc = nib[3] ? model_acc - diff : model_acc + diff; // bit 3 is the sign
    if (acc > 2047)
        acc = 2047;
    else if (acc < -2048)
        acc = -2048;
    idx = model_idx + int'(adpcm_index_adj[nib[2:0]]);
    if (idx < 0)
        idx = 0;
    else if (idx > 48)
        idx = 48;
    model_acc = acc;
    model_idx = idx;
endtask

task automatic wait_sample(input int limit, output bit got);
    int n;
    got = 1'b0;
    n   = 0;
    while (!got && n < limit) begin
        @(negedge clk);
        n++;
        got = sample;
    end
endtask

// sample and rom_cs must stay low
task automatic expect_quiet(input int n_cyc, input string what);
    int  i;
    bit  bad;
    bad = 1'b0;
    for (i = 0; i < n_cyc; i++) begin
        @(negedge clk);
        if (sample || rom_cs)
            bad = 1'b1;
    end
    if (bad)
        note_error(what);
endtask

// program pages, start, follow every sample against the model
task automatic play_pages(input logic [7:0] first_pg, input logic [7:0] last_pg,
                          input bit check_rail, input logic signed [11:0] rail,
                          output int n_samp, output bit rail_hit);
    int          wait_cyc;
    int          last_cyc;
    logic [15:0] exp_addr;
    logic [7:0]  exp_byte;
    logic [3:0]  nib;
    model_acc = 0;
    model_idx = 0;
    n_samp    = 0;
    rail_hit  = 1'b0;
    cpu_write(op_end_page, last_pg);
    cpu_write(op_start_page, first_pg);
    cpu_write(op_start, 8'h00);
    wait_cyc = 0;
    while (!rom_cs && wait_cyc < 20) begin
        @(negedge clk);
        wait_cyc++;
    end
    if (!rom_cs)
        note_error("rom_cs never rose after the start command");
    wait_cyc = 0;
    last_cyc = 0;
    while (rom_cs && wait_cyc < play_limit) begin
        @(negedge clk);
        wait_cyc++;
        if (sample) begin
            last_cyc = wait_cyc;
            // byte n/2 of the run, low nibble on even counts
            exp_addr = 16'(int'(first_pg) * (1 << pb_w) + n_samp / 2);
            exp_byte = rom[exp_addr];
            nib      = n_samp[0] ? exp_byte[7:4] : exp_byte[3:0];
            check_addr(rom_addr, exp_addr, "address at sample");
            model_step(nib);
            @(negedge clk); // snd moves on the edge after sample
            check_snd(snd, 12'(model_acc), "decoded sample");
            if (check_rail) begin
                if (rail_hit)
                    check_snd(snd, rail, "snd held at the rail");
                if (snd === rail)
                    rail_hit = 1'b1;
            end
            n_samp++;
        end
    end
    end_lag = wait_cyc - last_cyc;
    if (rom_cs)
        note_error("playback did not end at the end page");
endtask

task automatic verify_reset_state();
    @(negedge clk);
    check_snd(snd, 12'sd0, "snd after reset");
    check_bit(rom_cs, 1'b0, "rom_cs after reset");
    check_bit(sample, 1'b0, "sample after reset");
    check_addr(rom_addr, 16'h0000, "rom_addr after reset");
endtask

task automatic play_single_page();
    int n;
    bit hit;
    play_pages(8'd5, 8'd6, 1'b0, 12'sd0, n, hit);
    check_count(n, nib_per_page, "samples on page 5");
endtask

task automatic detect_page_end();
    int n;
    bit hit;
    play_pages(8'd10, 8'd11, 1'b0, 12'sd0, n, hit);
    check_count(n, nib_per_page, "samples before the end page");
    // page wrap, then page_done drops playing, then rom_cs follows
    check_count(end_lag, 2, "clocks from the last sample to rom_cs low");
    check_snd(snd, 12'sd0, "snd once idle");
    expect_quiet(30, "activity after the end page");
endtask

task automatic stop_mid_page();
    int i;
    bit got;
    cpu_write(op_end_page, 8'd50);
    cpu_write(op_start_page, 8'd40);
    cpu_write(op_start, 8'h00);
    for (i = 0; i < 5; i++) begin
        wait_sample(40, got);
        if (!got)
            note_error("no sample pulse before the stop command");
    end
    cpu_write(op_stop, 8'h00);
    @(posedge clk);   // playing already low
    @(negedge clk);
    check_bit(rom_cs, 1'b0, "rom_cs after stop");
    expect_quiet(40, "sample pulse after stop");
endtask

task automatic saturate_rails();
    int i;
    int n;
    bit hit;
    for (i = 0; i < (1 << pb_w); i++) begin
        rom[20 * (1 << pb_w) + i] = 8'h77; // +7 on both nibbles
        rom[30 * (1 << pb_w) + i] = 8'hff; // -7 on both nibbles
    end
    play_pages(8'd20, 8'd21, 1'b1, 12'sd2047, n, hit);
    check_bit(hit, 1'b1, "positive rail reached");
    play_pages(8'd30, 8'd31, 1'b1, -12'sd2048, n, hit);
    check_bit(hit, 1'b1, "negative rail reached");
endtask

task automatic ignore_unqualified_writes();
    write_raw(1'b0, 1'b1, op_end_page, 8'd61);
    write_raw(1'b0, 1'b1, op_start_page, 8'd60);
    write_raw(1'b0, 1'b1, op_start, 8'h00);
    write_raw(1'b1, 1'b0, op_start, 8'h00); // cs without cpu_cen
    expect_quiet(40, "playback started by an unqualified write");
endtask

initial begin
    int i;
    void'($urandom(32'h7fce));
    for (i = 0; i < 65536; i++)
        rom[i] = 8'($urandom);
    ad_rst   = 1'b0;
    cpu_cen  = 1'b1;
    cs       = 1'b0;
    cpu_ab   = op_start;
    cpu_dout = 8'h00;
    repeat (5) @(posedge clk);
    ad_rst <= 1'b1;

    verify_reset_state();
    play_single_page();
    detect_page_end();
    stop_mid_page();
    saturate_rails();
    ignore_unqualified_writes();

    $display("errors %0d in %0d checks", n_errors, n_checks);
    if (n_errors == 0)
        $display("sim passed");
    else
        $display("sim failed");
    $finish;
end

endmodule

//--- tb_clkgen.sv
// testbench clock source
// free running clock, 40 ns period
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int period = 40 // ns
) (
    output logic clk
);

initial clk = 1'b0;

always #(period / 2) clk = ~clk; // half period per phase

endmodule

//--- adpcm_player.sv
// ADPCM sample playback channel
// CPU registers, ROM sequencer and OKI decoder
`timescale 1ns/1ps

module adpcm_player import adpcm_pkg::*; #(
    parameter int page_bytes_w = 9,  // log2 of bytes per page
    parameter int rate_div     = 48  // cen_oki pulses per sample
) (
    input  logic               clk,
    input  logic               ad_rst,
    input  logic               cpu_cen,
    input  logic               cen_oki,
    input  logic [7:0]         cpu_dout,
    input  adpcm_op_e          cpu_ab,
    input  logic               cs,
    input  logic [7:0]         rom_data,
    output logic [15:0]        rom_addr,
    output logic               rom_cs,
    output logic signed [11:0] snd,
    output logic               sample
);

logic       playing;
logic       start_ld;
logic [7:0] start_page;
logic [7:0] end_page;
logic       page_done;
logic [3:0] din;       // nibble for the decoder

adpcm_regs u_regs (
    .clk        ( clk        ),
    .ad_rst     ( ad_rst     ),
    .cpu_cen    ( cpu_cen    ),
    .cs         ( cs         ),
    .cpu_ab     ( cpu_ab     ),
    .cpu_dout   ( cpu_dout   ),
    .page_done  ( page_done  ),
    .playing    ( playing    ),
    .start_ld   ( start_ld   ),
    .start_page ( start_page ),
    .end_page   ( end_page   )
);

adpcm_seq #(.page_bytes_w(page_bytes_w)) u_seq (
    .clk        ( clk        ),
    .ad_rst     ( ad_rst     ),
    .playing    ( playing    ),
    .start_ld   ( start_ld   ),
    .start_page ( start_page ),
    .end_page   ( end_page   ),
    .sample     ( sample     ),
    .rom_data   ( rom_data   ),
    .page_done  ( page_done  ),
    .rom_addr   ( rom_addr   ),
    .rom_cs     ( rom_cs     ),
    .din        ( din        )
);

adpcm_decoder #(.rate_div(rate_div)) u_decod (
    .clk        ( clk        ),
    .ad_rst     ( ad_rst     ),
    .playing    ( playing    ),
    .cen_oki    ( cen_oki    ),
    .din        ( din        ),
    .sample     ( sample     ),
    .snd        ( snd        )
);

endmodule

//--- adpcm_decoder.sv
// OKI style ADPCM decoder
// divides cen_oki down to the sample rate, then steps the
// 12-bit accumulator and the step index once per sample
`timescale 1ns/1ps

module adpcm_decoder import adpcm_pkg::*; #(
    parameter int rate_div = 48 // cen_oki pulses per sample
) (
    input  logic               clk,
    input  logic               ad_rst,
    input  logic               playing,
    input  logic               cen_oki,
    input  logic [3:0]         din,
    output logic               sample,
    output logic signed [11:0] snd
);

localparam int div_w = rate_div > 1 ? $clog2(rate_div) : 1;
localparam logic [div_w-1:0] div_last = div_w'(rate_div - 1);

logic [div_w-1:0]   div_cnt;
logic [5:0]         step_idx; // 0 to 48
logic [10:0]        step;
logic [11:0]        diff;     // at most 2910
logic signed [13:0] acc_sum;
logic signed [11:0] acc_nxt;
logic signed [6:0]  idx_sum;
logic [5:0]         idx_nxt;

// last cen_oki pulse of each period
assign sample = playing & cen_oki & (div_cnt == div_last);

// rate divider, held at 0 while idle
always_ff @(posedge clk) begin
    if (!ad_rst || !playing) begin
        div_cnt <= '0;
    end else if (cen_oki) begin
        if (sample)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + div_w'(1);
    end
end

assign step = adpcm_steps[step_idx];

// difference from the magnitude bits
always_comb begin
    diff = 12'(step >> 3);              // always there
    if (din[0])
        diff = diff + 12'(step >> 2);
    if (din[1])
        diff = diff + 12'(step >> 1);
    if (din[2])
        diff = diff + 12'(step);
end

// signed update with clipping to 12 bits
always_comb begin
    if (din[3])
        acc_sum = snd - $signed({2'b00, diff}); // bit 3 is the sign
    else
        acc_sum = snd + $signed({2'b00, diff});
    if (acc_sum > 14'sd2047)
        acc_nxt = 12'sd2047;
    else if (acc_sum < -14'sd2048)
        acc_nxt = -12'sd2048;
    else
        acc_nxt = acc_sum[11:0];
end

// next step index, kept inside the table
always_comb begin
    idx_sum = $signed({1'b0, step_idx}) + adpcm_index_adj[din[2:0]];
    if (idx_sum < 7'sd0)
        idx_nxt = 6'd0;
    else if (idx_sum > 7'(adpcm_max_idx))
        idx_nxt = 6'(adpcm_max_idx);
    else
        idx_nxt = idx_sum[5:0];
end

// accumulator and index step on each sample
always_ff @(posedge clk) begin
    if (!ad_rst || !playing) begin
        snd      <= 12'sd0;    // silent while idle
        step_idx <= 6'd0;
    end else if (sample) begin
        snd      <= acc_nxt;
        step_idx <= idx_nxt;
    end
end

endmodule

//--- adpcm_seq.sv
// ADPCM page and nibble sequencer
// walks the sample ROM a byte at a time, low nibble first,
// and flags the end page
`timescale 1ns/1ps

module adpcm_seq #(
    parameter int page_bytes_w = 9 // log2 of bytes per page
) (
    input  logic        clk,
    input  logic        ad_rst,
    input  logic        playing,
    input  logic        start_ld,
    input  logic [7:0]  start_page,
    input  logic [7:0]  end_page,
    input  logic        sample,
    input  logic [7:0]  rom_data,
    output logic        page_done,
    output logic [15:0] rom_addr,
    output logic        rom_cs,
    output logic [3:0]  din
);

logic [7:0]            page;    // running page
logic [page_bytes_w:0] nib_cnt; // byte count plus nibble select in bit 0
logic [15:0]           addr_nxt;

// stop as soon as the running page hits the end page
assign page_done = playing && (page == end_page);

// low page bits, then the byte offset inside the page
assign addr_nxt = 16'({page, nib_cnt[page_bytes_w:1]});

always_ff @(posedge clk) begin
    if (!ad_rst) begin
        page    <= 8'd0;
        nib_cnt <= '0;
    end else begin
        if (start_ld) begin
            page    <= start_page; // reload also while playing
            nib_cnt <= '0;
        end else if (!playing) begin
            nib_cnt <= '0;         // next start begins at byte 0
        end else if (sample) begin
            nib_cnt <= nib_cnt + 1'b1;
            if (&nib_cnt)
                page <= page + 8'd1; // last nibble of the page
        end
    end
end

// ROM request, one cycle behind the counters
always_ff @(posedge clk) begin
    if (!ad_rst) begin
        rom_addr <= 16'd0;
        rom_cs   <= 1'b0;
    end else begin
        rom_addr <= addr_nxt;
        rom_cs   <= playing;
    end
end

// even count takes bits 3:0, odd count bits 7:4
assign din = nib_cnt[0] ? rom_data[7:4] : rom_data[3:0];

endmodule

//--- adpcm_regs.sv
// ADPCM CPU register block
// decodes bus writes, keeps end page and play state,
// and passes the start page on to the sequencer
`timescale 1ns/1ps

module adpcm_regs import adpcm_pkg::*; (
    input  logic        clk,
    input  logic        ad_rst,
    input  logic        cpu_cen,
    input  logic        cs,
    input  adpcm_op_e   cpu_ab,
    input  logic [7:0]  cpu_dout,
    input  logic        page_done,
    output logic        playing,
    output logic        start_ld,
    output logic [7:0]  start_page,
    output logic [7:0]  end_page
);

play_state_e state;
logic        wr;

assign wr      = cs & cpu_cen; // qualified bus write
assign playing = state == st_play;

// play state, end page and start-load strobe
always_ff @(posedge clk) begin
    if (!ad_rst) begin
        state    <= st_idle;
        end_page <= 8'd0;
        start_ld <= 1'b0;
    end else begin
        start_ld <= 1'b0; // strobe lasts one cycle
        if (wr) begin
            case (cpu_ab)
                op_start: begin
                    if (state == st_idle)
                        state <= st_play; // ignored while already playing
                end
                op_end_page:   end_page <= cpu_dout;
                op_start_page: start_ld <= 1'b1;
                op_stop:       state    <= st_idle;
                default:       state    <= state;
            endcase
        end
        // end of data wins over a start in the same cycle
        if (page_done)
            state <= st_idle;
    end
end

// start page value, valid together with start_ld
always_ff @(posedge clk) begin
    if (wr && cpu_ab == op_start_page)
        start_page <= cpu_dout;
end

endmodule

//--- adpcm_pkg.sv
// ADPCM playback shared definitions
// register opcodes, player state, OKI step and index tables
package adpcm_pkg;

    // cpu register map, decoded from cpu_ab
    typedef enum logic [1:0] {
        op_start      = 2'd0, // begin playback
        op_end_page   = 2'd1, // last page, exclusive
        op_start_page = 2'd2, // first page to play
        op_stop       = 2'd3  // halt playback
    } adpcm_op_e;

    typedef enum logic {
        st_idle = 1'b0,
        st_play = 1'b1
    } play_state_e;

    // standard OKI step sizes, 49 entries
    localparam logic [10:0] adpcm_steps [49] = '{
        11'd16,   11'd17,   11'd19,   11'd21,   11'd23,   11'd25,   11'd28,
        11'd31,   11'd34,   11'd37,   11'd41,   11'd45,   11'd50,   11'd55,
        11'd60,   11'd66,   11'd73,   11'd80,   11'd88,   11'd97,   11'd107,
        11'd118,  11'd130,  11'd143,  11'd157,  11'd173,  11'd190,  11'd209,
        11'd230,  11'd253,  11'd279,  11'd307,  11'd337,  11'd371,  11'd408,
        11'd449,  11'd494,  11'd544,  11'd598,  11'd658,  11'd724,  11'd796,
        11'd876,  11'd963,  11'd1060, 11'd1166, 11'd1282, 11'd1411, 11'd1552
    };

    // index change per nibble magnitude
    // 5 bits wide so the +8 entry keeps its sign
    localparam logic signed [4:0] adpcm_index_adj [8] = '{
        -5'sd1,
        -5'sd1,
        -5'sd1,
        -5'sd1,
        5'sd2,
        5'sd4,
        5'sd6,
        5'sd8  // largest jump
    };

    localparam int adpcm_max_idx = 48; // last valid step index

endpackage
